//--- build.f
src/ppu_pkg.sv
src/vga_timing.sv
src/ppu_dot_counter.sv
src/ppu_background.sv
src/ppu_palette.sv
src/scanline_buffer.sv
src/ppu_top.sv
sim/tb_clock_gen.sv
sim/tb_ppu.sv

//--- run_sim.sh
#!/bin/sh
# Builds the PPU testbench with Verilator and runs it
# The result is taken from the pass line in sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ppu -f build.f -o tb_ppu_sim &&
./obj_dir/tb_ppu_sim | tee sim.log &&
grep -q "^TEST PASSED$" sim.log &&
echo "Simulation run passed" ||
{ echo "Simulation run failed, see sim.log"; exit 1; }

//--- sim/tb_ppu.sv
//----------------------------------------------------------------------
// Testbench for the background PPU on a 640x480 raster
// Video memory model answers one clock after each address
// Every tile is tile 0 with pixel value 1 and attribute 0
// Outputs are sampled on the falling clock edge
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_ppu;

    // Picture area in VGA pixels and lines
    localparam int PIC_X0 = 112;
    localparam int PIC_X1 = 624;
    localparam int PIC_Y0 = 33;
    localparam int PIC_Y1 = 513;
    // Visible pixels of a line, after the back porch
    localparam int VIS_X0 = 48;
    localparam int VIS_X1 = 688;
    localparam int LINE_CYCLES   = 800;
    localparam int FRAME_CYCLES  = LINE_CYCLES * 525;
    // Longest gap between dot steps, across the frame end
    localparam int DOT_GAP_LIMIT = 4000;

    logic        clock25;
    logic        reset_n;
    logic [3:0]  r;
    logic [3:0]  g;
    logic [3:0]  b;
    logic        hs;
    logic        vs;
    logic [8:0]  dot_x;
    logic [8:0]  dot_y;
    logic        cpu_ce;
    logic [13:0] vram_addr;
    logic [7:0]  vram_data = 8'h00;

    int check_count   = 0;
    int error_count   = 0;
    int timeout_count = 0;

    tb_clock_gen u_clock_gen (
        .clock25 (clock25),
        .reset_n (reset_n)
    );

    ppu_top u_ppu_top (
        .clock25     (clock25),
        .reset_n     (reset_n),
        .r_o         (r),
        .g_o         (g),
        .b_o         (b),
        .hs_o        (hs),
        .vs_o        (vs),
        .dot_x_o     (dot_x),
        .dot_y_o     (dot_y),
        .cpu_ce_o    (cpu_ce),
        .vram_addr_o (vram_addr),
        .vram_data_i (vram_data)
    );

    //------------------------------------------------------------------
    // Video memory model
    //------------------------------------------------------------------
    function automatic logic [7:0] vram_byte(input logic [13:0] addr);
        // Pattern planes, bit 3 picks the high plane
        if (addr < 14'h2000)
            return addr[3] ? 8'h00 : 8'hFF;
        // Nametable and attribute bytes
        return 8'h00;
    endfunction

    always @(posedge clock25) begin
        vram_data <= vram_byte(vram_addr);
    end

    //------------------------------------------------------------------
    // Helpers
    //------------------------------------------------------------------
    task automatic check_value(input string name, input int got, input int expected);
        check_count++;
        assert (got == expected) else begin
            error_count++;
            $display("[FAIL] %0t ns: %s expected %0h, got %0h", $time, name, expected, got);
        end
    endtask

    task automatic verify_range(input string name, input int got, input int lo, input int hi);
        check_count++;
        assert (got >= lo && got <= hi) else begin
            error_count++;
            $display("[FAIL] %0t ns: %s expected %0h to %0h, got %0h",
                     $time, name, lo, hi, got);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("Timeout at %0t ns while waiting for %s", $time, what);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clock25);
    endtask

    // 0 selects hs, anything else vs
    function automatic logic sync_level(input int which);
        return (which == 0) ? hs : vs;
    endfunction

    // Finds a whole low pulse and counts its low samples
    task automatic measure_low_pulse(input int which, input int limit, output int width);
        int guard;
        width = 0;
        guard = 0;
        @(negedge clock25);
        // Skip a pulse already in progress
        while (!sync_level(which) && guard < limit) begin
            @(negedge clock25);
            guard++;
        end
        while (sync_level(which) && guard < limit) begin
            @(negedge clock25);
            guard++;
        end
        while (!sync_level(which) && guard < limit) begin
            @(negedge clock25);
            guard++;
            width++;
        end
        if (guard >= limit)
            report_timeout((which == 0) ? "a full hs pulse" : "a full vs pulse");
    endtask

    //------------------------------------------------------------------
    // Directed tests
    //------------------------------------------------------------------
    task automatic time_sync_pulses();
        int width;
        int i;
        for (i = 0; i < 3; i++) begin
            measure_low_pulse(0, 2 * LINE_CYCLES, width);
            check_value("hs low cycles", width, 96);
        end
        // Two lines of vs per frame
        measure_low_pulse(1, 2 * FRAME_CYCLES + LINE_CYCLES, width);
        check_value("vs low cycles", width, 2 * LINE_CYCLES);
    endtask

    task automatic trace_dot_counters();
        logic [8:0] prev_x;
        logic [8:0] prev_y;
        int         wraps;
        int         guard;
        @(negedge clock25);
        prev_x = dot_x;
        prev_y = dot_y;
        wraps  = 0;
        guard  = 0;
        // Three full wraps of dot_x
        while (wraps < 3 && guard < DOT_GAP_LIMIT) begin
            @(negedge clock25);
            guard++;
            if (dot_x != prev_x) begin
                guard = 0;
                if (prev_x == 9'd340) begin
                    check_value("dot_x", dot_x, 0);
                    check_value("dot_y", dot_y, prev_y + 1);
                    wraps++;
                end else begin
                    check_value("dot_x", dot_x, prev_x + 1);
                end
            end
            prev_x = dot_x;
            prev_y = dot_y;
        end
        if (guard >= DOT_GAP_LIMIT)
            report_timeout("dot_x to advance");
    endtask

    task automatic count_cpu_enables();
        logic [8:0] prev_x;
        int         dots;
        int         dots_since;
        int         pulses;
        int         guard;
        bit         seen_pulse;
        @(negedge clock25);
        prev_x = dot_x;
        guard  = 0;
        // Line start, dot_x just wrapped to 0
        while (!(dot_x == 9'd0 && prev_x == 9'd340) && guard < 2 * DOT_GAP_LIMIT) begin
            prev_x = dot_x;
            @(negedge clock25);
            guard++;
        end
        if (guard >= 2 * DOT_GAP_LIMIT) begin
            report_timeout("dot_x to wrap");
            return;
        end
        prev_x     = dot_x;
        dots       = 0;
        dots_since = 0;
        pulses     = 0;
        seen_pulse = 1'b0;
        guard      = 0;
        while (dots < 341 && guard < DOT_GAP_LIMIT) begin
            @(negedge clock25);
            guard++;
            if (dot_x != prev_x) begin
                dots++;
                dots_since++;
                guard = 0;
            end
            if (cpu_ce) begin
                // Three dots per CPU cycle
                if (seen_pulse)
                    check_value("dots between cpu_ce pulses", dots_since, 3);
                seen_pulse = 1'b1;
                dots_since = 0;
                pulses++;
            end
            prev_x = dot_x;
        end
        if (guard >= DOT_GAP_LIMIT)
            report_timeout("dot_x to advance");
        // 341 dots over a period of three
        verify_range("cpu_ce pulses per line", pulses, 113, 114);
    endtask

    task automatic scan_vram_addresses();
        int guard;
        int cycle;
        int name_samples;
        int row;
        @(negedge clock25);
        guard = 0;
        // First dot of a picture line with 20 lines to go
        while (!(dot_y >= 9'd16 && dot_y < 9'd236 && dot_x == 9'd0) &&
               guard < 2 * FRAME_CYCLES) begin
            @(negedge clock25);
            guard++;
        end
        if (guard >= 2 * FRAME_CYCLES) begin
            report_timeout("a picture line to start");
            return;
        end
        name_samples = 0;
        for (cycle = 0; cycle < 20 * 2 * LINE_CYCLES; cycle++) begin
            if (dot_y >= 9'd16 && dot_y < 9'd256) begin
                row = (dot_y - 16) / 8;
                verify_range("vram_addr", vram_addr, 14'h0000, 14'h2FFF);
                if (vram_addr < 14'h2000) begin
                    // Tile 0, row within the tile from fine Y
                    check_value("pattern fine Y", vram_addr[2:0], (dot_y - 16) % 8);
                    check_value("pattern tile", vram_addr[11:4], 0);
                end else if (vram_addr[9:6] != 4'hF) begin
                    name_samples++;
                    check_value("nametable row", vram_addr[9:5], row);
                    check_value("vertical nametable bit", vram_addr[11], 0);
                    // Only the tile past column 31 lands in the next nametable
                    if (vram_addr[10])
                        check_value("wrapped nametable column", vram_addr[4:0], 0);
                    else
                        verify_range("nametable address", vram_addr, 14'h2000, 14'h23BF);
                end
            end
            @(negedge clock25);
        end
        verify_range("nametable samples", name_samples, 1, 20 * 2 * LINE_CYCLES);
    endtask

    task automatic compare_frame_pixels();
        logic prev_vs;
        int   guard;
        int   x;
        int   y;
        int   cycle;
        @(negedge clock25);
        prev_vs = vs;
        guard   = 0;
        // Frame start is where vs rises
        while (!(vs && !prev_vs) && guard < 2 * FRAME_CYCLES) begin
            prev_vs = vs;
            @(negedge clock25);
            guard++;
        end
        if (guard >= 2 * FRAME_CYCLES) begin
            report_timeout("vs to rise");
            return;
        end
        x = 0;
        y = 0;
        for (cycle = 0; cycle < FRAME_CYCLES; cycle++) begin
            // Picture edges settle within a few pixels
            if (y >= PIC_Y0 && y < PIC_Y1 && x >= PIC_X0 + 4 && x < PIC_X1) begin
                check_value("rgb", {r, g, b}, 12'hD20);
            end else if (y < PIC_Y0 || y >= PIC_Y1 || x < VIS_X0 || x >= VIS_X1 + 4) begin
                check_value("rgb", {r, g, b}, 12'h000);
            end
            x++;
            if (x == LINE_CYCLES) begin
                x = 0;
                y++;
            end
            @(negedge clock25);
        end
    endtask

    //------------------------------------------------------------------
    // Test sequence
    //------------------------------------------------------------------
    initial begin
        int guard;
        void'($urandom(32'h5606));
        guard = 0;
        while (reset_n !== 1'b1 && guard < 100) begin
            @(negedge clock25);
            guard++;
        end
        if (guard >= 100)
            report_timeout("reset release");

        time_sync_pulses();
        idle_cycles($urandom_range(40, 5));
        trace_dot_counters();
        idle_cycles($urandom_range(40, 5));
        count_cpu_enables();
        idle_cycles($urandom_range(40, 5));
        scan_vram_addresses();
        idle_cycles($urandom_range(40, 5));
        compare_frame_pixels();

        $display("Checks: %0d, value errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0 && check_count > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
//----------------------------------------------------------------------
// Clock and reset source for the PPU testbench
// 4 ns clock period, reset held low for the first 5 rising edges
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 5
) (
    output logic clock25,
    output logic reset_n
);

    initial begin
        clock25 = 1'b0;
        forever #HALF_PERIOD clock25 = ~clock25;
    end

    // Release lands on a rising edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock25);
        reset_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- src/ppu_top.sv
//----------------------------------------------------------------------
// Background-only tile PPU on a 640x480 VGA raster
// Video memory must answer within one dot
// Sprites and the CPU register interface are not present
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ppu_top #(
    parameter int PAL_RESET_TABLE_SEL = 0,
    parameter int BUF_DEPTH           = 256
) (
    input  logic                clock25,
    input  logic                reset_n,
    output logic [3:0]          r_o,
    output logic [3:0]          g_o,
    output logic [3:0]          b_o,
    output logic                hs_o,
    output logic                vs_o,
    output logic [8:0]          dot_x_o,
    output logic [8:0]          dot_y_o,
    output logic                cpu_ce_o,
    output ppu_pkg::vram_addr_t vram_addr_o,
    input  logic [7:0]          vram_data_i
);
    import ppu_pkg::*;

    logic [9:0] beam_x;
    logic [9:0] beam_y;
    logic       visible;
    logic       border;
    logic       dot_window;
    logic       frame_end;
    logic       dot_ce;
    logic       paper;
    logic [3:0] bg_pixel;
    logic [7:0] buf_addr;
    logic       buf_we;
    color_idx_t idx_wr;
    color_idx_t idx_rd;
    rgb_t       rgb;

    vga_timing u_vga_timing (
        .clock25      (clock25),
        .reset_n      (reset_n),
        .beam_x_o     (beam_x),
        .beam_y_o     (beam_y),
        .hs_o         (hs_o),
        .vs_o         (vs_o),
        .visible_o    (visible),
        .border_o     (border),
        .dot_window_o (dot_window),
        .line_end_o   (),
        .frame_end_o  (frame_end)
    );

    ppu_dot_counter u_dot_counter (
        .clock25      (clock25),
        .reset_n      (reset_n),
        .beam_x_i     (beam_x),
        .beam_y_i     (beam_y),
        .dot_window_i (dot_window),
        .frame_end_i  (frame_end),
        .dot_x_o      (dot_x_o),
        .dot_y_o      (dot_y_o),
        .dot_ce_o     (dot_ce),
        .cpu_ce_o     (cpu_ce_o),
        .paper_o      (paper)
    );

    ppu_background u_background (
        .clock25     (clock25),
        .reset_n     (reset_n),
        .dot_ce_i    (dot_ce),
        .dot_x_i     (dot_x_o),
        .dot_y_i     (dot_y_o),
        .vram_addr_o (vram_addr_o),
        .vram_data_i (vram_data_i),
        .bg_pixel_o  (bg_pixel)
    );

    ppu_palette #(
        .PAL_RESET_TABLE_SEL (PAL_RESET_TABLE_SEL)
    ) u_palette (
        .clock25    (clock25),
        .reset_n    (reset_n),
        .dot_ce_i   (dot_ce),
        .paper_i    (paper),
        .visible_i  (visible),
        .border_i   (border),
        .beam_x_i   (beam_x),
        .beam_y_i   (beam_y),
        .dot_y_i    (dot_y_o),
        .bg_pixel_i (bg_pixel),
        .buf_addr_o (buf_addr),
        .idx_wr_o   (idx_wr),
        .buf_we_o   (buf_we),
        .idx_rd_i   (idx_rd),
        .rgb_o      (rgb)
    );

    // Same slot address serves write and read lines
    scanline_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_line_buf (
        .clock25   (clock25),
        .we_i      (buf_we),
        .addr_i    (buf_addr),
        .data_i    (idx_wr),
        .rd_addr_i (buf_addr),
        .data_o    (idx_rd)
    );

    assign {r_o, g_o, b_o} = rgb;

endmodule

`default_nettype wire

//--- src/scanline_buffer.sv
//----------------------------------------------------------------------
// Line buffer of colour indices for VGA line doubling
// Separate write and read addresses, read data is registered
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module scanline_buffer #(
    parameter int BUF_DEPTH = 256
) (
    input  logic                         clock25,
    input  logic                         we_i,
    input  logic [$clog2(BUF_DEPTH)-1:0] addr_i,
    input  ppu_pkg::color_idx_t          data_i,
    input  logic [$clog2(BUF_DEPTH)-1:0] rd_addr_i,
    output ppu_pkg::color_idx_t          data_o
);

    logic [5:0] mem [BUF_DEPTH];

    // One write and one read port, block RAM friendly
    always_ff @(posedge clock25) begin
        if (we_i)
            mem[addr_i] <= data_i;
        data_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

//--- src/ppu_palette.sv
//----------------------------------------------------------------------
// Background palette and RGB output register
// Palette entries load at reset and stay fixed
// Odd lines show live dots and fill the line buffer
// Even lines replay the buffer, two cycles of read latency included
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ppu_palette #(
    parameter int PAL_RESET_TABLE_SEL = 0
) (
    input  logic                clock25,
    input  logic                reset_n,
    input  logic                dot_ce_i,
    input  logic                paper_i,
    input  logic                visible_i,
    input  logic                border_i,
    input  logic [9:0]          beam_x_i,
    input  logic [9:0]          beam_y_i,
    input  logic [8:0]          dot_y_i,
    input  logic [3:0]          bg_pixel_i,
    output logic [7:0]          buf_addr_o,
    output ppu_pkg::color_idx_t idx_wr_o,
    output logic                buf_we_o,
    input  ppu_pkg::color_idx_t idx_rd_i,
    output ppu_pkg::rgb_t       rgb_o
);
    import ppu_pkg::*;

    localparam color_idx_t PAL_TABLE_0 [16] = '{
        6'h0F, 6'h16, 6'h30, 6'h38, 6'h00, 6'h16, 6'h26, 6'h07,
        6'h00, 6'h26, 6'h00, 6'h30, 6'h00, 6'h38, 6'h28, 6'h10
    };
    localparam color_idx_t PAL_TABLE_1 [16] = '{
        6'h0F, 6'h16, 6'h27, 6'h12, 6'h0F, 6'h30, 6'h2B, 6'h16,
        6'h0F, 6'h39, 6'h28, 6'h27, 6'h0F, 6'h30, 6'h30, 6'h30
    };

    color_idx_t bg_pal [16];
    color_idx_t cur_idx;
    color_idx_t pal_color;
    logic [3:0] pal_sel;
    logic [9:0] beam_rel;
    logic [7:0] dot_addr;
    logic       replay_line;

    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            for (int i = 0; i < 16; i++) begin
                bg_pal[i] <= (PAL_RESET_TABLE_SEL == 1) ? PAL_TABLE_1[i] : PAL_TABLE_0[i];
            end
        end
    end

    // Transparent pixel falls back to entry 0
    assign pal_sel   = (bg_pixel_i[1:0] == 2'b00) ? 4'd0 : bg_pixel_i;
    assign pal_color = bg_pal[pal_sel];

    // Buffer slot of the current dot
    // Even lines look one pixel ahead to hide read latency
    assign beam_rel    = beam_x_i + {9'd0, ~beam_y_i[0]} - H_BACK;
    assign dot_addr    = beam_rel[8:1] - PAPER_X0[7:0];
    assign replay_line = (dot_y_i > PAPER_Y0) && (dot_y_i <= PAPER_Y1);

    //------------------------------------------------------------------
    // Line buffer write side
    //------------------------------------------------------------------
    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            buf_we_o <= 1'b0;
        end else begin
            buf_we_o <= dot_ce_i && paper_i;
        end
    end

    always_ff @(posedge clock25) begin
        buf_addr_o <= dot_addr;
        idx_wr_o   <= pal_color;
    end

    //------------------------------------------------------------------
    // Output colour select
    //------------------------------------------------------------------
    always_ff @(posedge clock25) begin
        if (!visible_i) begin
            cur_idx <= 6'h3F;
        end else if (border_i) begin
            cur_idx <= bg_pal[0];
        end else if (beam_y_i[0]) begin
            if (dot_ce_i && paper_i)
                cur_idx <= pal_color;
        end else if (beam_x_i[0] && replay_line) begin
            cur_idx <= idx_rd_i;
        end
        rgb_o <= master_rgb(cur_idx);
    end

endmodule

`default_nettype wire

//--- src/ppu_background.sv
//----------------------------------------------------------------------
// Background tile fetch, scroll counters and pixel select
// Fetch runs on dots 24 to 287, one tile every eight dots
// Video memory data is sampled one dot after each address
// Scroll preset is fixed at zero and pattern half 1 is used
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ppu_background (
    input  logic                clock25,
    input  logic                reset_n,
    input  logic                dot_ce_i,
    input  logic [8:0]          dot_x_i,
    input  logic [8:0]          dot_y_i,
    output ppu_pkg::vram_addr_t vram_addr_o,
    input  logic [7:0]          vram_data_i,
    output logic [3:0]          bg_pixel_o
);
    import ppu_pkg::*;

    // Pattern table half after reset
    localparam logic       BG_PATTERN_HALF = 1'b1;
    localparam logic [8:0] FETCH_START     = PAPER_X0 - 9'd8;
    localparam logic [8:0] FETCH_END       = PAPER_X0 + PAPER_W;
    localparam logic [8:0] HORIZ_RELOAD    = PAPER_X0 + PAPER_W + 9'd4;
    localparam logic [8:0] VERT_RELOAD     = PAPER_X0 + PAPER_W + 9'd8;

    fetch_phase_e phase;
    logic [4:0]   coarse_x;
    logic [4:0]   coarse_y;
    logic [2:0]   fine_y;
    logic         nt_h;
    logic         nt_v;
    logic [7:0]   pat_lo;
    logic [7:0]   pat_hi;
    logic [15:0]  tile;
    logic [1:0]   tile_attr;
    logic         fetch_on;
    logic [2:0]   attr_shift;
    logic [2:0]   bit_sel;
    logic [1:0]   pix;

    assign fetch_on   = (dot_x_i >= FETCH_START) && (dot_x_i < FETCH_END);
    // Quadrant of the 32x32 attribute area
    assign attr_shift = {coarse_y[1], coarse_x[1], 1'b0};

    //------------------------------------------------------------------
    // Fetch sequencer and scroll counters
    //------------------------------------------------------------------
    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            phase       <= PH_IDLE0;
            coarse_x    <= 5'd0;
            coarse_y    <= 5'd0;
            fine_y      <= 3'd0;
            nt_h        <= 1'b0;
            nt_v        <= 1'b0;
            vram_addr_o <= '0;
        end else if (dot_ce_i) begin
            if (fetch_on) begin
                phase <= fetch_phase_e'(phase + 3'd1);
                case (phase)
                    // Nametable at 0x2000
                    PH_NAME_REQ:
                        vram_addr_o <= {2'b10, nt_v, nt_h, coarse_y, coarse_x};
                    // Tile number arrives, low plane first
                    PH_PATTERN_REQ:
                        vram_addr_o <= {1'b0, BG_PATTERN_HALF, vram_data_i, 1'b0, fine_y};
                    // High plane is 8 bytes on
                    PH_PATTERN_LO:
                        vram_addr_o[3] <= 1'b1;
                    PH_ATTR_REQ:
                        vram_addr_o <= {2'b10, nt_v, nt_h, 4'b1111,
                                        coarse_y[4:2], coarse_x[4:2]};
                    // Coarse X step, horizontal nametable flips past 31
                    PH_LATCH: begin
                        if (coarse_x == 5'd31)
                            nt_h <= ~nt_h;
                        coarse_x <= coarse_x + 5'd1;
                    end
                    default: ;
                endcase
            end

            // End of line, horizontal reload and Y step
            if (dot_x_i == HORIZ_RELOAD) begin
                coarse_x <= 5'd0;
                nt_h     <= 1'b0;
                fine_y   <= fine_y + 3'd1;
                if (fine_y == 3'd7) begin
                    if (coarse_y == 5'd29) begin
                        coarse_y <= 5'd0;
                        nt_v     <= ~nt_v;
                    end else if (coarse_y == 5'd31) begin
                        coarse_y <= 5'd0;
                    end else begin
                        coarse_y <= coarse_y + 5'd1;
                    end
                end
            end

            // Vertical reload on the line before the picture
            if (dot_x_i == VERT_RELOAD && dot_y_i == PAPER_Y0 - 9'd1) begin
                fine_y   <= 3'd0;
                coarse_y <= 5'd0;
                nt_v     <= 1'b0;
            end
        end
    end

    //------------------------------------------------------------------
    // Pattern and attribute latches
    //------------------------------------------------------------------
    always_ff @(posedge clock25) begin
        if (dot_ce_i && fetch_on) begin
            case (phase)
                PH_PATTERN_LO: pat_lo <= vram_data_i;
                PH_ATTR_REQ:   pat_hi <= vram_data_i;
                PH_LATCH: begin
                    tile      <= {pat_hi, pat_lo};
                    tile_attr <= vram_data_i[attr_shift +: 2];
                end
                default: ;
            endcase
        end
    end

    // Phase doubles as fine X, MSB is the leftmost pixel
    assign bit_sel    = ~phase;
    assign pix        = {tile[{1'b1, bit_sel}], tile[{1'b0, bit_sel}]};
    assign bg_pixel_o = (pix != 2'b00) ? {tile_attr, pix} : 4'd0;

endmodule

`default_nettype wire

//--- src/ppu_dot_counter.sv
//----------------------------------------------------------------------
// Processor dot counters with dot and CPU clock enables
// Dots advance only on odd pixels of odd VGA lines
// CPU enable divides the dot rate by three and runs across lines
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ppu_dot_counter (
    input  logic       clock25,
    input  logic       reset_n,
    input  logic [9:0] beam_x_i,
    input  logic [9:0] beam_y_i,
    input  logic       dot_window_i,
    input  logic       frame_end_i,
    output logic [8:0] dot_x_o,
    output logic [8:0] dot_y_o,
    output logic       dot_ce_o,
    output logic       cpu_ce_o,
    output logic       paper_o
);
    import ppu_pkg::*;

    logic       dot_tick;
    logic [1:0] cpu_div;

    // Odd pixel on odd line inside the dot window
    assign dot_tick = dot_window_i && beam_x_i[0] && beam_y_i[0];

    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            dot_x_o <= 9'd0;
            dot_y_o <= PAPER_Y0;
            cpu_div <= 2'd0;
        end else if (frame_end_i) begin
            dot_x_o <= 9'd0;
            dot_y_o <= 9'd0;
        end else if (dot_tick) begin
            // Three dots per CPU cycle
            cpu_div <= (cpu_div == 2'd2) ? 2'd0 : cpu_div + 2'd1;
            if (dot_x_o == DOTS_PER_LINE - 9'd1) begin
                dot_x_o <= 9'd0;
                dot_y_o <= dot_y_o + 9'd1;
            end else begin
                dot_x_o <= dot_x_o + 9'd1;
            end
        end
    end

    assign dot_ce_o = dot_tick;
    assign cpu_ce_o = dot_tick && (cpu_div == 2'd0);

    // Picture area in dot coordinates
    assign paper_o = (dot_x_o >= PAPER_X0) && (dot_x_o < PAPER_X0 + PAPER_W) &&
                     (dot_y_o >= PAPER_Y0) && (dot_y_o < PAPER_Y1);

endmodule

`default_nettype wire

//--- src/vga_timing.sv
//----------------------------------------------------------------------
// VGA beam counters and active-low syncs for 640x480
// Beam starts on line 1 after reset so the first dot line is odd
// Dot window spans 682 pixels, two per processor dot
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module vga_timing (
    input  logic       clock25,
    input  logic       reset_n,
    output logic [9:0] beam_x_o,
    output logic [9:0] beam_y_o,
    output logic       hs_o,
    output logic       vs_o,
    output logic       visible_o,
    output logic       border_o,
    output logic       dot_window_o,
    output logic       line_end_o,
    output logic       frame_end_o
);
    import ppu_pkg::*;

    // Sync pulses follow visible area and front porch
    localparam logic [9:0] HS_START = H_BACK + H_VISIBLE + H_FRONT;
    localparam logic [9:0] VS_START = V_BACK + V_VISIBLE + V_FRONT;

    logic h_visible;
    logic v_visible;

    //------------------------------------------------------------------
    // Beam counters
    //------------------------------------------------------------------
    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            beam_x_o <= 10'd0;
            beam_y_o <= 10'd1;
        end else if (frame_end_o) begin
            beam_x_o <= 10'd0;
            beam_y_o <= 10'd0;
        end else if (line_end_o) begin
            beam_x_o <= 10'd0;
            beam_y_o <= beam_y_o + 10'd1;
        end else begin
            beam_x_o <= beam_x_o + 10'd1;
        end
    end

    assign line_end_o  = (beam_x_o == H_TOTAL - 10'd1);
    assign frame_end_o = line_end_o && (beam_y_o == V_TOTAL - 10'd1);

    // Syncs, low during the pulse
    assign hs_o = !(beam_x_o >= HS_START && beam_x_o < HS_START + H_SYNC);
    assign vs_o = !(beam_y_o >= VS_START && beam_y_o < VS_START + V_SYNC);

    assign h_visible = (beam_x_o >= H_BACK) && (beam_x_o < H_BACK + H_VISIBLE);
    assign v_visible = (beam_y_o >= V_BACK) && (beam_y_o < V_BACK + V_VISIBLE);
    assign visible_o = h_visible && v_visible;

    // Border left and right of the 512 pixel picture
    assign border_o = visible_o && ((beam_x_o < H_BACK + BORDER_X0) ||
                                    (beam_x_o >= H_BACK + BORDER_X0 + 2 * PAPER_W));

    assign dot_window_o = (beam_x_o >= H_BACK) &&
                          (beam_x_o < H_BACK + 2 * DOTS_PER_LINE);

endmodule

`default_nettype wire

//--- src/ppu_pkg.sv
//----------------------------------------------------------------------
// Shared timing, geometry and colour definitions for the background PPU
// VGA timing is the standard 640x480 mode at a 25 MHz pixel clock
// One processor dot covers a 2x2 block of VGA pixels
//----------------------------------------------------------------------
`default_nettype none

package ppu_pkg;

    // Horizontal VGA timing in pixels
    localparam logic [9:0] H_VISIBLE = 10'd640;
    localparam logic [9:0] H_FRONT   = 10'd16;
    localparam logic [9:0] H_SYNC    = 10'd96;
    localparam logic [9:0] H_BACK    = 10'd48;
    localparam logic [9:0] H_TOTAL   = 10'd800;

    // Vertical VGA timing in lines
    localparam logic [9:0] V_VISIBLE = 10'd480;
    localparam logic [9:0] V_FRONT   = 10'd10;
    localparam logic [9:0] V_SYNC    = 10'd2;
    localparam logic [9:0] V_BACK    = 10'd33;
    localparam logic [9:0] V_TOTAL   = 10'd525;

    // Processor dot geometry
    localparam logic [8:0] DOTS_PER_LINE = 9'd341;
    localparam logic [8:0] PAPER_X0      = 9'd32;
    localparam logic [8:0] PAPER_W       = 9'd256;
    localparam logic [8:0] PAPER_Y0      = 9'd16;
    localparam logic [8:0] PAPER_Y1      = 9'd256;

    // Picture offset inside the visible VGA line
    localparam logic [9:0] BORDER_X0 = 10'd64;

    typedef logic [5:0]  color_idx_t;
    typedef logic [11:0] rgb_t;
    typedef logic [13:0] vram_addr_t;

    // One phase per dot, eight dots per tile
    typedef enum logic [2:0] {
        PH_IDLE0,
        PH_IDLE1,
        PH_IDLE2,
        PH_NAME_REQ,
        PH_PATTERN_REQ,
        PH_PATTERN_LO,
        PH_ATTR_REQ,
        PH_LATCH
    } fetch_phase_e;

    // Master palette, 4 bits per channel as RGB
    localparam rgb_t MASTER_TABLE [64] = '{
        12'h777, 12'h218, 12'h00A, 12'h409, 12'h807, 12'hA01, 12'hA00, 12'h700,
        12'h420, 12'h040, 12'h050, 12'h031, 12'h135, 12'h000, 12'h000, 12'h000,
        12'hBBB, 12'h07E, 12'h23E, 12'h80F, 12'hB0B, 12'hE05, 12'hD20, 12'hC40,
        12'h870, 12'h090, 12'h0A0, 12'h093, 12'h088, 12'h000, 12'h000, 12'h000,
        12'hFFF, 12'h3BF, 12'h59F, 12'hA8F, 12'hF7F, 12'hF7B, 12'hF76, 12'hF93,
        12'hFB3, 12'h8D1, 12'h4D4, 12'h5F9, 12'h0ED, 12'h000, 12'h000, 12'h000,
        12'hFFF, 12'hAEF, 12'hCDF, 12'hDCF, 12'hFCF, 12'hFCD, 12'hFBB, 12'hFDA,
        12'hFEA, 12'hEFA, 12'hAFB, 12'hBFC, 12'h9FF, 12'h000, 12'h000, 12'h000
    };

    // Colour index to RGB
    function automatic rgb_t master_rgb(input color_idx_t idx);
        return MASTER_TABLE[idx];
    endfunction

endpackage

`default_nettype wire
